//--- Makefile
TOP = video_output_tb

sim:
	verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f project.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- project.f
+incdir+source
source/raster_types_pkg.sv
source/video_config_pkg.sv
source/video_config_regs.sv
source/raster_control.sv
source/line_buffer_reader.sv
source/sync_generator.sv
source/pixel_output_stage.sv
source/video_output_top.sv
verification/video_output_tb.sv

//--- source/line_buffer_reader.sv
`timescale 1ns/100ps
`default_nettype none

`include "video_defines.svh"

module line_buffer_reader (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           running,
    input  raster_types_pkg::coord_t       raster_x,
    input  raster_types_pkg::coord_t       raster_y,
    input  raster_types_pkg::coord_t       h_active,
    input  video_config_pkg::repeat_t      rep_h,
    input  video_config_pkg::repeat_t      rep_v,
    input  raster_types_pkg::buffer_addr_t line_length,
    input  raster_types_pkg::buffer_addr_t ram_words,
    output raster_types_pkg::buffer_addr_t rdaddr
);
    import raster_types_pkg::*;
    import video_config_pkg::*;

    // stored values belong to the current position
    buffer_addr_t col_q;
    buffer_addr_t base_q;
    repeat_t      rep_x_q;
    repeat_t      rep_y_q;

    buffer_addr_t cur_col;
    buffer_addr_t cur_base;
    repeat_t      cur_rep_x;
    repeat_t      cur_rep_y;
    repeat_t      rep_h_last;
    repeat_t      rep_v_last;

    logic [`VIDEO_ADDR_WIDTH:0] base_sum;

    // a factor of 0 counts as 1
    assign rep_h_last = (rep_h == '0) ? '0 : rep_h - 1'b1;
    assign rep_v_last = (rep_v == '0) ? '0 : rep_v - 1'b1;
    assign base_sum   = {1'b0, base_q} + {1'b0, line_length};

    always_comb begin
        // column restarts at every line
        cur_col   = (raster_x == '0) ? '0 : col_q;
        cur_rep_x = (raster_x == '0) ? '0 : rep_x_q;

        cur_base  = base_q;
        cur_rep_y = rep_y_q;
        if (raster_x == '0 && raster_y == '0) begin
            cur_base  = '0;
            cur_rep_y = '0;
        end else if (raster_x == '0) begin
            if (rep_y_q == rep_v_last) begin
                cur_rep_y = '0;
                // wrap before the base runs past the buffer
                cur_base  = (base_sum >= {1'b0, ram_words}) ?
                            '0 : base_sum[`VIDEO_ADDR_WIDTH-1:0];
            end else begin
                cur_rep_y = rep_y_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            col_q   <= '0;
            rep_x_q <= '0;
            base_q  <= '0;
            rep_y_q <= '0;
            rdaddr  <= '0;
        end else if (!running) begin
            col_q   <= '0;
            rep_x_q <= '0;
            base_q  <= '0;
            rep_y_q <= '0;
            rdaddr  <= '0;
        end else begin
            if (cur_rep_x == rep_h_last) begin
                col_q   <= cur_col + 1'b1;
                rep_x_q <= '0;
            end else begin
                col_q   <= cur_col;
                rep_x_q <= cur_rep_x + 1'b1;
            end
            base_q  <= cur_base;
            rep_y_q <= cur_rep_y;
            // blanking columns read word 0
            rdaddr  <= (raster_x < h_active) ? cur_base + cur_col : '0;
        end
    end

endmodule

`default_nettype wire

//--- source/pixel_output_stage.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_output_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     live,
    input  raster_types_pkg::coord_t raster_x,
    input  raster_types_pkg::coord_t raster_y,
    input  raster_types_pkg::coord_t h_active,
    input  raster_types_pkg::coord_t v_active,
    input  raster_types_pkg::pixel_t rddata,
    output raster_types_pkg::pixel_t video_out,
    output logic                     draw_area
);

    logic       in_area;
    // two stages, meets rddata one cycle after the registered address
    logic [1:0] area_pipe;

    assign in_area = (raster_x < h_active) && (raster_y < v_active);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            area_pipe <= '0;
        end else begin
            area_pipe <= {area_pipe[0], live && in_area};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register, black outside the draw area
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            video_out <= '0;
            draw_area <= 1'b0;
        end else begin
            video_out <= area_pipe[1] ? rddata : '0;
            draw_area <= area_pipe[1];
        end
    end

endmodule

`default_nettype wire

//--- source/raster_control.sv
`timescale 1ns/100ps
`default_nettype none

module raster_control (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start,
    input  raster_types_pkg::coord_t h_total,
    input  raster_types_pkg::coord_t v_total,
    output raster_types_pkg::coord_t raster_x,
    output raster_types_pkg::coord_t raster_y,
    output logic                     frame_start,
    output logic                     running,
    output logic                     live
);
    import raster_types_pkg::*;

    raster_state_t state;
    logic          line_end;
    logic          frame_end;

    assign line_end  = raster_x >= h_total - 1'b1;
    assign frame_end = line_end && (raster_y >= v_total - 1'b1);

    assign running     = state != raster_idle;
    assign live        = state == raster_active;
    assign frame_start = running && (raster_x == '0) && (raster_y == '0);

    ////////////////////////////////////////////////////////////////////////////
    // idle -> one warm-up frame -> active
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= raster_idle;
            raster_x <= '0;
            raster_y <= '0;
        end else if (!start) begin
            // start cleared, back to idle
            state    <= raster_idle;
            raster_x <= '0;
            raster_y <= '0;
        end else begin
            case (state)
                raster_idle: begin
                    state    <= raster_warmup;
                    raster_x <= '0;
                    raster_y <= '0;
                end
                default: begin
                    // go live on the edge into the next (0,0)
                    if (frame_end) begin
                        state <= raster_active;
                    end

                    if (line_end) begin
                        raster_x <= '0;
                        if (frame_end) begin
                            raster_y <= '0;
                        end else begin
                            raster_y <= raster_y + 1'b1;
                        end
                    end else begin
                        raster_x <= raster_x + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/raster_types_pkg.sv
`default_nettype none

`include "video_defines.svh"

package raster_types_pkg;

    // raster position or timing value in pixels/lines
    typedef logic [`VIDEO_COORD_WIDTH-1:0] coord_t;

    // word address into the line buffer
    typedef logic [`VIDEO_ADDR_WIDTH-1:0] buffer_addr_t;

    // rgb 8:8:8
    typedef logic [`VIDEO_PIXEL_WIDTH-1:0] pixel_t;

    typedef enum logic [1:0] {
        raster_idle,
        raster_warmup,
        raster_active
    } raster_state_t;

endpackage

`default_nettype wire

//--- source/sync_generator.sv
`timescale 1ns/100ps
`default_nettype none

module sync_generator (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     live,
    input  logic                     h_polarity,
    input  logic                     v_polarity,
    input  raster_types_pkg::coord_t raster_x,
    input  raster_types_pkg::coord_t raster_y,
    input  raster_types_pkg::coord_t h_sync_start,
    input  raster_types_pkg::coord_t h_sync_width,
    input  raster_types_pkg::coord_t v_sync_start,
    input  raster_types_pkg::coord_t v_sync_width,
    output logic                     hsync,
    output logic                     vsync
);

    logic       h_window;
    logic       v_window;
    // active-high sync, 3 stages to match the pixel path
    logic [2:0] h_pipe;
    logic [2:0] v_pipe;

    // one extra bit so start + width cannot overflow
    assign h_window = (raster_x >= h_sync_start)
                   && ({1'b0, raster_x} < {1'b0, h_sync_start} + {1'b0, h_sync_width});
    assign v_window = (raster_y >= v_sync_start)
                   && ({1'b0, raster_y} < {1'b0, v_sync_start} + {1'b0, v_sync_width});

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            h_pipe <= '0;
            v_pipe <= '0;
        end else begin
            h_pipe <= {h_pipe[1:0], live && h_window};
            v_pipe <= {v_pipe[1:0], live && v_window};
        end
    end

    // polarity 1 means active high
    assign hsync = h_pipe[2] ~^ h_polarity;
    assign vsync = v_pipe[2] ~^ v_polarity;

endmodule

`default_nettype wire

//--- source/video_config_pkg.sv
`default_nettype none

`include "video_defines.svh"

package video_config_pkg;

    // repetition factor, 0 behaves like 1
    typedef logic [2:0] repeat_t;

    // apb bus vectors
    typedef logic [`VIDEO_APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [`VIDEO_APB_DATA_WIDTH-1:0] apb_data_t;

endpackage

`default_nettype wire

//--- source/video_config_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "video_defines.svh"

module video_config_regs (
    input  logic                         clock,
    input  logic                         reset,
    input  video_config_pkg::apb_addr_t  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  video_config_pkg::apb_data_t  pwdata,
    output video_config_pkg::apb_data_t  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output raster_types_pkg::coord_t     h_total,
    output raster_types_pkg::coord_t     h_active,
    output raster_types_pkg::coord_t     h_sync_start,
    output raster_types_pkg::coord_t     h_sync_width,
    output raster_types_pkg::coord_t     v_total,
    output raster_types_pkg::coord_t     v_active,
    output raster_types_pkg::coord_t     v_sync_start,
    output raster_types_pkg::coord_t     v_sync_width,
    output logic                         h_polarity,
    output logic                         v_polarity,
    output logic                         start,
    output video_config_pkg::repeat_t    rep_h,
    output video_config_pkg::repeat_t    rep_v,
    output raster_types_pkg::buffer_addr_t line_length,
    output raster_types_pkg::buffer_addr_t ram_words
);
    import video_config_pkg::*;

    logic      access;
    logic      hit;
    apb_data_t read_value;

    assign access  = psel && penable;
    assign pready  = 1'b1;
    assign pslverr = access && !hit;
    assign prdata  = read_value;

    ////////////////////////////////////////////////////////////////////////////
    // address decode and readback
    always_comb begin
        hit        = 1'b1;
        read_value = '0;
        case (paddr)
            `REG_CONTROL:      read_value = apb_data_t'(start);
            `REG_H_TOTAL:      read_value = apb_data_t'(h_total);
            `REG_H_ACTIVE:     read_value = apb_data_t'(h_active);
            `REG_H_SYNC_START: read_value = apb_data_t'(h_sync_start);
            `REG_H_SYNC_WIDTH: read_value = apb_data_t'(h_sync_width);
            `REG_V_TOTAL:      read_value = apb_data_t'(v_total);
            `REG_V_ACTIVE:     read_value = apb_data_t'(v_active);
            `REG_V_SYNC_START: read_value = apb_data_t'(v_sync_start);
            `REG_V_SYNC_WIDTH: read_value = apb_data_t'(v_sync_width);
            `REG_POLARITY:     read_value = apb_data_t'({v_polarity, h_polarity});
            `REG_REPEAT:       read_value = apb_data_t'({rep_v, 1'b0, rep_h});
            `REG_LINE_LENGTH:  read_value = apb_data_t'(line_length);
            `REG_RAM_WORDS:    read_value = apb_data_t'(ram_words);
            default:           hit = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // mode registers, defaults give a small 32x16 mode
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            start        <= 1'b0;
            h_total      <= `VIDEO_COORD_WIDTH'(40);
            h_active     <= `VIDEO_COORD_WIDTH'(32);
            h_sync_start <= `VIDEO_COORD_WIDTH'(34);
            h_sync_width <= `VIDEO_COORD_WIDTH'(3);
            v_total      <= `VIDEO_COORD_WIDTH'(20);
            v_active     <= `VIDEO_COORD_WIDTH'(16);
            v_sync_start <= `VIDEO_COORD_WIDTH'(17);
            v_sync_width <= `VIDEO_COORD_WIDTH'(2);
            h_polarity   <= 1'b1;
            v_polarity   <= 1'b1;
            rep_h        <= 3'd1;
            rep_v        <= 3'd1;
            line_length  <= `VIDEO_ADDR_WIDTH'(32);
            ram_words    <= `VIDEO_ADDR_WIDTH'(512);
        end else if (access && pwrite) begin
            case (paddr)
                `REG_CONTROL:      start        <= pwdata[0];
                `REG_H_TOTAL:      h_total      <= pwdata[`VIDEO_COORD_WIDTH-1:0];
                `REG_H_ACTIVE:     h_active     <= pwdata[`VIDEO_COORD_WIDTH-1:0];
                `REG_H_SYNC_START: h_sync_start <= pwdata[`VIDEO_COORD_WIDTH-1:0];
                `REG_H_SYNC_WIDTH: h_sync_width <= pwdata[`VIDEO_COORD_WIDTH-1:0];
                `REG_V_TOTAL:      v_total      <= pwdata[`VIDEO_COORD_WIDTH-1:0];
                `REG_V_ACTIVE:     v_active     <= pwdata[`VIDEO_COORD_WIDTH-1:0];
                `REG_V_SYNC_START: v_sync_start <= pwdata[`VIDEO_COORD_WIDTH-1:0];
                `REG_V_SYNC_WIDTH: v_sync_width <= pwdata[`VIDEO_COORD_WIDTH-1:0];
                `REG_POLARITY: begin
                    h_polarity <= pwdata[0];
                    v_polarity <= pwdata[1];
                end
                // rep_h in bits 2:0, rep_v in bits 6:4
                `REG_REPEAT: begin
                    rep_h <= pwdata[2:0];
                    rep_v <= pwdata[6:4];
                end
                `REG_LINE_LENGTH:  line_length  <= pwdata[`VIDEO_ADDR_WIDTH-1:0];
                `REG_RAM_WORDS:    ram_words    <= pwdata[`VIDEO_ADDR_WIDTH-1:0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/video_defines.svh
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// datapath widths
`define VIDEO_COORD_WIDTH     12
`define VIDEO_ADDR_WIDTH      14
`define VIDEO_PIXEL_WIDTH     24
`define VIDEO_APB_ADDR_WIDTH  8
`define VIDEO_APB_DATA_WIDTH  32

// register map, byte offsets
`define REG_CONTROL       8'h00
`define REG_H_TOTAL       8'h04
`define REG_H_ACTIVE      8'h08
`define REG_H_SYNC_START  8'h0c
`define REG_H_SYNC_WIDTH  8'h10
`define REG_V_TOTAL       8'h14
`define REG_V_ACTIVE      8'h18
`define REG_V_SYNC_START  8'h1c
`define REG_V_SYNC_WIDTH  8'h20
`define REG_POLARITY      8'h24
`define REG_REPEAT        8'h28
`define REG_LINE_LENGTH   8'h2c
`define REG_RAM_WORDS     8'h30

`endif

//--- source/video_output_top.sv
`timescale 1ns/100ps
`default_nettype none

module video_output_top (
    input  logic                           clock,
    input  logic                           reset,
    input  video_config_pkg::apb_addr_t    paddr,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  video_config_pkg::apb_data_t    pwdata,
    output video_config_pkg::apb_data_t    prdata,
    output logic                           pready,
    output logic                           pslverr,
    output raster_types_pkg::buffer_addr_t rdaddr,
    input  raster_types_pkg::pixel_t       rddata,
    output raster_types_pkg::pixel_t       video_out,
    output logic                           hsync,
    output logic                           vsync,
    output logic                           draw_area,
    output logic                           frame_live
);
    import raster_types_pkg::*;
    import video_config_pkg::*;

    // mode settings
    coord_t       h_total;
    coord_t       h_active;
    coord_t       h_sync_start;
    coord_t       h_sync_width;
    coord_t       v_total;
    coord_t       v_active;
    coord_t       v_sync_start;
    coord_t       v_sync_width;
    logic         h_polarity;
    logic         v_polarity;
    logic         start;
    repeat_t      rep_h;
    repeat_t      rep_v;
    buffer_addr_t line_length;
    buffer_addr_t ram_words;

    // raster position and control
    coord_t       raster_x;
    coord_t       raster_y;
    logic         running;

    video_config_regs u_regs (
        .clock        (clock),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .h_total      (h_total),
        .h_active     (h_active),
        .h_sync_start (h_sync_start),
        .h_sync_width (h_sync_width),
        .v_total      (v_total),
        .v_active     (v_active),
        .v_sync_start (v_sync_start),
        .v_sync_width (v_sync_width),
        .h_polarity   (h_polarity),
        .v_polarity   (v_polarity),
        .start        (start),
        .rep_h        (rep_h),
        .rep_v        (rep_v),
        .line_length  (line_length),
        .ram_words    (ram_words)
    );

    // frame_start is a monitor point only
    raster_control u_control (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .h_total     (h_total),
        .v_total     (v_total),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .frame_start (),
        .running     (running),
        .live        (frame_live)
    );

    line_buffer_reader u_reader (
        .clock       (clock),
        .reset       (reset),
        .running     (running),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .h_active    (h_active),
        .rep_h       (rep_h),
        .rep_v       (rep_v),
        .line_length (line_length),
        .ram_words   (ram_words),
        .rdaddr      (rdaddr)
    );

    sync_generator u_sync (
        .clock        (clock),
        .reset        (reset),
        .live         (frame_live),
        .h_polarity   (h_polarity),
        .v_polarity   (v_polarity),
        .raster_x     (raster_x),
        .raster_y     (raster_y),
        .h_sync_start (h_sync_start),
        .h_sync_width (h_sync_width),
        .v_sync_start (v_sync_start),
        .v_sync_width (v_sync_width),
        .hsync        (hsync),
        .vsync        (vsync)
    );

    pixel_output_stage u_pixel (
        .clock     (clock),
        .reset     (reset),
        .live      (frame_live),
        .raster_x  (raster_x),
        .raster_y  (raster_y),
        .h_active  (h_active),
        .v_active  (v_active),
        .rddata    (rddata),
        .video_out (video_out),
        .draw_area (draw_area)
    );

endmodule

`default_nettype wire

//--- verification/video_output_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "video_defines.svh"

module video_output_tb;
    import raster_types_pkg::*;
    import video_config_pkg::*;

    localparam int clock_period = 8;

    // 40x20 raster with a 32x16 visible area
    localparam int mode_h_total      = 40;
    localparam int mode_h_active     = 32;
    localparam int mode_h_sync_start = 34;
    localparam int mode_h_sync_width = 3;
    localparam int mode_v_total      = 20;
    localparam int mode_v_active     = 16;
    localparam int mode_v_sync_start = 17;
    localparam int mode_v_sync_width = 2;
    localparam int frame_cycles      = mode_h_total * mode_v_total;

    // warm-up and walked frames summed over all tests
    localparam int test_frames = 7;
    localparam int timeout_ns  = test_frames * frame_cycles * 4 * clock_period + 10000;

    logic         clock = 1'b0;
    logic         reset;
    apb_addr_t    paddr;
    logic         psel;
    logic         penable;
    logic         pwrite;
    apb_data_t    pwdata;
    apb_data_t    prdata;
    logic         pready;
    logic         pslverr;
    buffer_addr_t rdaddr;
    pixel_t       rddata = '0;
    pixel_t       video_out;
    logic         hsync;
    logic         vsync;
    logic         draw_area;
    logic         frame_live;

    // line-buffer RAM model
    pixel_t       ram [0:(1 << `VIDEO_ADDR_WIDTH) - 1];
    buffer_addr_t ram_addr_q = '0;
    integer       seed;

    // mode the checks expect
    logic h_pol_cfg;
    logic v_pol_cfg;
    int   rep_h_cfg;
    int   rep_v_cfg;
    int   line_length_cfg;
    int   ram_words_cfg;

    video_output_top dut_i (
        .clock      (clock),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .rdaddr     (rdaddr),
        .rddata     (rddata),
        .video_out  (video_out),
        .hsync      (hsync),
        .vsync      (vsync),
        .draw_area  (draw_area),
        .frame_live (frame_live)
    );

    always #(clock_period / 2) clock = ~clock;

    // data for an address shows up one clock after the address
    always @(posedge clock) begin
        #1;
        rddata     = ram[ram_addr_q];
        ram_addr_q = rdaddr;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the tests were still running after %0d ns", timeout_ns);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus and check helpers

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic step;
        @(posedge clock);
        #1;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        step();
        penable = 1'b1;
        step();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data,
                            output logic error);
        paddr   = addr;
        pwdata  = '0;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        step();
        penable = 1'b1;
        // prdata is combinational in the access phase
        #2;
        data  = prdata;
        error = pslverr;
        check_value("pready", 1, pready);
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_data_t read_data;
        logic      read_error;
        apb_write(addr, data);
        apb_read(addr, read_data, read_error);
        check_value($sformatf("prdata at 0x%0h", addr), data, read_data);
        check_value("pslverr", 0, read_error);
    endtask

    task automatic set_mode(input int polarity, input int rep_h, input int rep_v,
                            input int line_len, input int words);
        write_reg(`REG_H_TOTAL, mode_h_total);
        write_reg(`REG_H_ACTIVE, mode_h_active);
        write_reg(`REG_H_SYNC_START, mode_h_sync_start);
        write_reg(`REG_H_SYNC_WIDTH, mode_h_sync_width);
        write_reg(`REG_V_TOTAL, mode_v_total);
        write_reg(`REG_V_ACTIVE, mode_v_active);
        write_reg(`REG_V_SYNC_START, mode_v_sync_start);
        write_reg(`REG_V_SYNC_WIDTH, mode_v_sync_width);
        write_reg(`REG_POLARITY, polarity);
        // rep_v sits in bits 6:4
        write_reg(`REG_REPEAT, (rep_v << 4) | rep_h);
        write_reg(`REG_LINE_LENGTH, line_len);
        write_reg(`REG_RAM_WORDS, words);
        h_pol_cfg       = polarity[0];
        v_pol_cfg       = polarity[1];
        rep_h_cfg       = (rep_h == 0) ? 1 : rep_h;
        rep_v_cfg       = (rep_v == 0) ? 1 : rep_v;
        line_length_cfg = line_len;
        ram_words_cfg   = words;
    endtask

    // buffer line bases step by line_length and wrap at ram_words
    function automatic int expected_address(input int x, input int y);
        int base;
        int line;
        base = 0;
        for (line = 0; line < y / rep_v_cfg; line++) begin
            if (base + line_length_cfg >= ram_words_cfg) begin
                base = 0;
            end else begin
                base = base + line_length_cfg;
            end
        end
        return (base + x / rep_h_cfg) % (1 << `VIDEO_ADDR_WIDTH);
    endfunction

    task automatic check_outputs_blank;
        check_value("hsync", !h_pol_cfg, hsync);
        check_value("vsync", !v_pol_cfg, vsync);
        check_value("draw_area", 0, draw_area);
        check_value("video_out", 0, video_out);
    endtask

    task automatic check_inactive;
        check_value("frame_live", 0, frame_live);
        check_value("rdaddr", 0, rdaddr);
        check_outputs_blank();
    endtask

    task automatic start_raster;
        int cycles;
        apb_write(`REG_CONTROL, 32'h1);
        cycles = 0;
        while (frame_live !== 1'b1 && cycles < frame_cycles + 16) begin
            check_outputs_blank();
            step();
            cycles++;
        end
        // one cycle to leave idle, then the warm-up frame
        check_value("frame_live delay", frame_cycles + 1, cycles);
    endtask

    task automatic stop_raster;
        apb_write(`REG_CONTROL, 32'h0);
        // idle one cycle later, then three pipeline stages
        repeat (4) step();
        check_inactive();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one live frame, every output position checked

    task automatic walk_frame;
        int   k;
        int   x;
        int   y;
        int   ahead;
        int   ax;
        int   ay;
        logic h_window;
        logic v_window;
        logic in_area;
        // position (0,0) reaches the pins three cycles after going live
        repeat (3) step();
        for (k = 0; k < frame_cycles; k++) begin
            x        = k % mode_h_total;
            y        = k / mode_h_total;
            h_window = x >= mode_h_sync_start && x < mode_h_sync_start + mode_h_sync_width;
            v_window = y >= mode_v_sync_start && y < mode_v_sync_start + mode_v_sync_width;
            in_area  = x < mode_h_active && y < mode_v_active;
            check_value("frame_live", 1, frame_live);
            check_value("hsync", h_window ? h_pol_cfg : !h_pol_cfg, hsync);
            check_value("vsync", v_window ? v_pol_cfg : !v_pol_cfg, vsync);
            check_value("draw_area", in_area, draw_area);
            if (in_area) begin
                check_value("video_out", ram[expected_address(x, y)], video_out);
            end else begin
                check_value("video_out", 0, video_out);
            end

            // the read address runs two positions ahead of the pins
            ahead = (k + 2) % frame_cycles;
            ax    = ahead % mode_h_total;
            ay    = ahead / mode_h_total;
            if (ax < mode_h_active) begin
                check_value("rdaddr", expected_address(ax, ay), rdaddr);
            end else begin
                check_value("rdaddr", 0, rdaddr);
            end
            step();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_registers;
        apb_data_t data;
        logic      error;
        // reset polarity is active high on both syncs
        h_pol_cfg = 1'b1;
        v_pol_cfg = 1'b1;
        check_inactive();
        apb_read(8'h34, data, error);
        check_value("pslverr", 1, error);
        check_value("prdata", 0, data);
        apb_read(8'hfc, data, error);
        check_value("pslverr", 1, error);
        check_value("prdata", 0, data);
        apb_write(8'h34, 32'h0000_0fff);
        apb_read(`REG_H_TOTAL, data, error);
        check_value("prdata", mode_h_total, data);
        // values away from the reset defaults
        write_reg(`REG_H_TOTAL, 32'h0123);
        write_reg(`REG_H_ACTIVE, 32'h0456);
        write_reg(`REG_H_SYNC_START, 32'h0789);
        write_reg(`REG_H_SYNC_WIDTH, 32'h0abc);
        write_reg(`REG_V_TOTAL, 32'h0def);
        write_reg(`REG_V_ACTIVE, 32'h0321);
        write_reg(`REG_V_SYNC_START, 32'h0654);
        write_reg(`REG_V_SYNC_WIDTH, 32'h0987);
        write_reg(`REG_POLARITY, 32'h2);
        write_reg(`REG_REPEAT, 32'h53);
        write_reg(`REG_LINE_LENGTH, 32'h2cba);
        write_reg(`REG_RAM_WORDS, 32'h1fed);
        // hsync active high, vsync active low
        set_mode(2'b01, 1, 1, 32, 512);
        check_inactive();
    endtask

    task automatic test_go_live;
        apb_data_t data;
        logic      error;
        start_raster();
        apb_read(`REG_CONTROL, data, error);
        check_value("control", 1, data);
        stop_raster();
        apb_read(`REG_CONTROL, data, error);
        check_value("control", 0, data);
    endtask

    task automatic test_horizontal_timing;
        set_mode(2'b11, 1, 1, 32, 512);
        start_raster();
        walk_frame();
        stop_raster();
    endtask

    task automatic test_vertical_polarity;
        // both syncs active low
        set_mode(2'b00, 1, 1, 32, 512);
        check_inactive();
        start_raster();
        walk_frame();
        stop_raster();
    endtask

    task automatic test_pixel_repetition;
        // 8 buffer lines of 16 words in an 80 word buffer wrap after 5
        set_mode(2'b11, 2, 2, 16, 80);
        start_raster();
        walk_frame();
        stop_raster();
    endtask

    initial begin
        integer i;
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        seed    = 32'h7310_546f;
        for (i = 0; i < (1 << `VIDEO_ADDR_WIDTH); i++) begin
            ram[i] = pixel_t'($random(seed));
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        step();

        test_registers();
        test_go_live();
        test_horizontal_timing();
        test_vertical_polarity();
        test_pixel_repetition();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
